// ==== source/synth_pkg.sv ====
package synth_pkg;

	////////////////////////////////////////////////////////////
	// sizes and timing
	////////////////////////////////////////////////////////////

	localparam int NUM_VOICES   = 8;
	localparam int VOICE_W      = 3;
	localparam int CLKS_PER_BIT = 320; // 10 MHz over 31250 baud
	localparam int FRAME_CLKS   = 256; // about 39 kHz audio frames
	localparam int PHASE_W      = 16;

	// phase steps for notes 120 to 131, one octave shift per 12 notes below that
	localparam logic [PHASE_W-1:0] SEMITONE_INC [12] = '{
		16'd14046, 16'd14881, 16'd15766, 16'd16704,
		16'd17697, 16'd18749, 16'd19864, 16'd21045,
		16'd22297, 16'd23623, 16'd25027, 16'd26515
	};

	////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		KIND_NOTE_ON,
		KIND_NOTE_OFF,
		KIND_CTRL,
		KIND_OTHER
	} midi_kind_e;

	typedef enum logic [1:0] {
		WAVE_SAW,
		WAVE_SQUARE,
		WAVE_TRI
	} wave_e;

	typedef struct packed {
		midi_kind_e kind;
		logic [6:0] note;
		logic [6:0] velocity;
	} midi_event_t;

	typedef struct packed {
		logic       start;
		logic       stop;
		logic [6:0] note;
		logic [6:0] velocity;
	} voice_cmd_t;

	typedef struct packed {
		logic               busy;
		logic [6:0]         note;
		logic [6:0]         velocity;
		logic [PHASE_W-1:0] phase;
	} voice_state_t;

endpackage

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
	input  logic       MHz10,
	input  logic       nrst,
	input  logic       ser_in,
	output logic [7:0] byte_data,
	output logic       byte_valid
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e state;
	logic [1:0] ser_sync;
	logic rx;
	logic [$clog2(synth_pkg::CLKS_PER_BIT)-1:0] timer;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic half_end;
	logic bit_end;

	assign rx = ser_sync[1];
	assign half_end = int'(timer) == synth_pkg::CLKS_PER_BIT / 2 - 1;
	assign bit_end = int'(timer) == synth_pkg::CLKS_PER_BIT - 1;
	assign byte_data = shift;

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			ser_sync <= 2'b11; // line idles high
			state <= RX_IDLE;
			timer <= '0;
			bit_cnt <= '0;
			byte_valid <= 1'b0;
		end else begin
			ser_sync <= {ser_sync[0], ser_in};
			byte_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					timer <= '0;
					if (!rx)
						state <= RX_START;
				end
				RX_START: begin
					timer <= timer + 1'b1;
					if (half_end) begin
						timer <= '0;
						bit_cnt <= '0;
						state <= rx ? RX_IDLE : RX_DATA; // a glitch is not a start bit
					end
				end
				RX_DATA: begin
					timer <= timer + 1'b1;
					if (bit_end) begin
						timer <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					timer <= timer + 1'b1;
					if (bit_end) begin
						state <= RX_IDLE;
						byte_valid <= rx; // framing error drops the byte
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge MHz10) begin
		if (state == RX_DATA && bit_end)
			shift <= {rx, shift[7:1]};
	end

	a_single_strobe: assert property (@(posedge MHz10) disable iff (!nrst)
		byte_valid |=> !byte_valid);

endmodule

// ==== source/midi_parser.sv ====
`timescale 1ns/1ps

module midi_parser (
	input  logic                   MHz10,
	input  logic                   nrst,
	input  logic [7:0]             byte_data,
	input  logic                   byte_valid,
	output synth_pkg::midi_event_t midi_event,
	output logic                   event_valid,
	output logic                   sustain
);

	typedef enum logic [1:0] {
		P_STATUS,
		P_NOTE,
		P_VEL
	} parse_state_e;

	parse_state_e state;
	synth_pkg::midi_kind_e kind_q;
	synth_pkg::midi_kind_e new_kind;
	logic [6:0] note_q;
	logic is_status;
	logic msg_done;

	function automatic synth_pkg::midi_kind_e decode_kind(input logic [3:0] nib);
		case (nib)
			4'h9:    return synth_pkg::KIND_NOTE_ON;
			4'h8:    return synth_pkg::KIND_NOTE_OFF;
			4'hb:    return synth_pkg::KIND_CTRL;
			default: return synth_pkg::KIND_OTHER;
		endcase
	endfunction

	assign is_status = byte_valid && byte_data[7];
	assign new_kind = decode_kind(byte_data[7:4]);
	assign msg_done = byte_valid && !byte_data[7] && state == P_VEL;

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			state <= P_STATUS;
			kind_q <= synth_pkg::KIND_OTHER;
			event_valid <= 1'b0;
			sustain <= 1'b0;
		end else begin
			event_valid <= msg_done && kind_q != synth_pkg::KIND_CTRL;
			if (is_status) begin
				kind_q <= new_kind;
				// unsupported messages are skipped along with their data bytes
				state <= (new_kind == synth_pkg::KIND_OTHER) ? P_STATUS : P_NOTE;
			end else if (byte_valid) begin
				case (state)
					P_NOTE:  state <= P_VEL;
					P_VEL:   state <= P_STATUS; // no running status
					default: state <= P_STATUS;
				endcase
			end
			if (msg_done && kind_q == synth_pkg::KIND_CTRL && note_q == 7'd64)
				sustain <= byte_data[6]; // pedal down from 64 upwards
		end
	end

	always_ff @(posedge MHz10) begin
		if (byte_valid && !byte_data[7] && state == P_NOTE)
			note_q <= byte_data[6:0];
		if (msg_done) begin
			// a note on with zero velocity is a release
			midi_event.kind <= (kind_q == synth_pkg::KIND_NOTE_ON && byte_data[6:0] == 7'd0)
				? synth_pkg::KIND_NOTE_OFF : kind_q;
			midi_event.note <= note_q;
			midi_event.velocity <= byte_data[6:0];
		end
	end

	a_event_kind: assert property (@(posedge MHz10) disable iff (!nrst)
		event_valid |-> midi_event.kind != synth_pkg::KIND_OTHER
			&& midi_event.kind != synth_pkg::KIND_CTRL);

endmodule

// ==== source/voice_alloc.sv ====
`timescale 1ns/1ps

module voice_alloc (
	input  logic                    MHz10,
	input  logic                    nrst,
	input  synth_pkg::midi_event_t  midi_event,
	input  logic                    event_valid,
	input  synth_pkg::voice_state_t states [synth_pkg::NUM_VOICES],
	output synth_pkg::voice_cmd_t   cmd [synth_pkg::NUM_VOICES]
);

	logic found;
	logic [synth_pkg::VOICE_W-1:0] free_idx;
	logic is_on;
	logic is_off;
	logic [synth_pkg::NUM_VOICES-1:0] start_vec;
	logic [synth_pkg::NUM_VOICES-1:0] busy_vec;

	assign is_on = event_valid && midi_event.kind == synth_pkg::KIND_NOTE_ON;
	assign is_off = event_valid && midi_event.kind == synth_pkg::KIND_NOTE_OFF;

	// scan from the top so the lowest free index wins
	always_comb begin
		found = 1'b0;
		free_idx = '0;
		for (int i = synth_pkg::NUM_VOICES - 1; i >= 0; i--) begin
			if (!states[i].busy) begin
				found = 1'b1;
				free_idx = i[synth_pkg::VOICE_W-1:0];
			end
		end
	end

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			for (int k = 0; k < synth_pkg::NUM_VOICES; k++)
				cmd[k] <= '0;
		end else begin
			for (int k = 0; k < synth_pkg::NUM_VOICES; k++) begin
				cmd[k].start <= is_on && found && int'(free_idx) == k; // full means dropped
				cmd[k].stop <= is_off && states[k].busy && states[k].note == midi_event.note;
				cmd[k].note <= midi_event.note;
				cmd[k].velocity <= midi_event.velocity;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < synth_pkg::NUM_VOICES; k++) begin
			start_vec[k] = cmd[k].start;
			busy_vec[k] = states[k].busy;
		end
	end

	// the voice being started still shows its old busy bit in this cycle
	a_one_start: assert property (@(posedge MHz10) disable iff (!nrst)
		$onehot0(start_vec) && (start_vec & busy_vec) == '0);

endmodule

// ==== source/voice_osc.sv ====
`timescale 1ns/1ps

module voice_osc (
	input  logic                    MHz10,
	input  logic                    nrst,
	input  synth_pkg::voice_cmd_t   cmd,
	input  logic                    sustain,
	input  logic                    frame_tick,
	output synth_pkg::voice_state_t state
);

	logic busy;
	logic released;
	logic [6:0] note;
	logic [6:0] velocity;
	logic [synth_pkg::PHASE_W-1:0] phase;
	logic [3:0] octave;
	logic [3:0] semi;
	logic [synth_pkg::PHASE_W-1:0] inc;

	////////////////////////////////////////////////////////////
	// pitch
	////////////////////////////////////////////////////////////

	assign octave = 4'(note / 7'd12); // 0 to 10
	assign semi = 4'(note % 7'd12);
	assign inc = synth_pkg::SEMITONE_INC[semi] >> (4'd10 - octave);

	////////////////////////////////////////////////////////////
	// gate and hold
	////////////////////////////////////////////////////////////

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			busy <= 1'b0;
			released <= 1'b0;
		end else if (cmd.start) begin
			busy <= 1'b1;
			released <= 1'b0;
		end else if ((cmd.stop || released) && !sustain) begin
			busy <= 1'b0;
			released <= 1'b0;
		end else if (cmd.stop && busy) begin
			released <= 1'b1; // held by the pedal until it lifts
		end
	end

	always_ff @(posedge MHz10) begin
		if (cmd.start) begin
			note <= cmd.note;
			velocity <= cmd.velocity;
			phase <= '0;
		end else if (busy && frame_tick) begin
			phase <= phase + inc;
		end
	end

	assign state.busy = busy;
	assign state.note = note;
	assign state.velocity = velocity;
	assign state.phase = phase;

endmodule

// ==== source/voice_mixer.sv ====
`timescale 1ns/1ps

module voice_mixer (
	input  logic                    MHz10,
	input  logic                    nrst,
	input  logic                    wave_btn,
	input  synth_pkg::voice_state_t states [synth_pkg::NUM_VOICES],
	output logic                    frame_tick,
	output logic [11:0]             sample_out,
	output logic                    sample_valid
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_READ,
		M_DONE
	} mix_state_e;

	mix_state_e mix_state;
	logic [$clog2(synth_pkg::FRAME_CLKS)-1:0] frame_cnt;
	logic [synth_pkg::VOICE_W-1:0] rd_sel;
	synth_pkg::voice_state_t cur;
	logic [7:0] p;
	logic [7:0] shaped;
	logic [14:0] prod;
	logic [8:0] contrib;
	logic [11:0] acc;
	logic [2:0] btn_sync;
	logic btn_press;
	synth_pkg::wave_e wave_mode;

	////////////////////////////////////////////////////////////
	// frame timer and wave button
	////////////////////////////////////////////////////////////

	assign btn_press = btn_sync[1] && !btn_sync[2];

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			frame_cnt <= '0;
			frame_tick <= 1'b0;
			btn_sync <= '0;
			wave_mode <= synth_pkg::WAVE_SAW;
		end else begin
			frame_tick <= int'(frame_cnt) == synth_pkg::FRAME_CLKS - 1;
			frame_cnt <= (int'(frame_cnt) == synth_pkg::FRAME_CLKS - 1) ? '0 : frame_cnt + 1'b1;
			btn_sync <= {btn_sync[1:0], wave_btn};
			if (btn_press) begin
				case (wave_mode)
					synth_pkg::WAVE_SAW:    wave_mode <= synth_pkg::WAVE_SQUARE;
					synth_pkg::WAVE_SQUARE: wave_mode <= synth_pkg::WAVE_TRI;
					default:                wave_mode <= synth_pkg::WAVE_SAW;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// shaper and scaling for the voice on the read bus
	////////////////////////////////////////////////////////////

	assign cur = states[rd_sel];
	assign p = cur.phase[synth_pkg::PHASE_W-1 -: 8];

	always_comb begin
		case (wave_mode)
			synth_pkg::WAVE_SQUARE: shaped = p[7] ? 8'hff : 8'h00;
			synth_pkg::WAVE_TRI:    shaped = p[7] ? ~{p[6:0], 1'b0} : {p[6:0], 1'b0};
			default:                shaped = p;
		endcase
	end

	assign prod = shaped * cur.velocity;
	assign contrib = cur.busy ? prod[14:6] : 9'd0; // eight of these still fit in 12 bits

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			mix_state <= M_IDLE;
			rd_sel <= '0;
			acc <= '0;
			sample_out <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			case (mix_state)
				M_IDLE: if (frame_tick) begin
					acc <= '0;
					rd_sel <= '0;
					mix_state <= M_READ;
				end
				M_READ: begin
					acc <= acc + {3'b000, contrib};
					if (int'(rd_sel) == synth_pkg::NUM_VOICES - 1)
						mix_state <= M_DONE;
					else
						rd_sel <= rd_sel + 1'b1;
				end
				M_DONE: begin
					sample_out <= acc;
					sample_valid <= 1'b1;
					mix_state <= M_IDLE;
				end
				default: mix_state <= M_IDLE;
			endcase
		end
	end

	a_sweep_done: assert property (@(posedge MHz10) disable iff (!nrst)
		sample_valid |-> $past(mix_state == M_DONE)
			&& int'($past(rd_sel)) == synth_pkg::NUM_VOICES - 1);

endmodule

// ==== source/poly_synth.sv ====
`timescale 1ns/1ps

module poly_synth (
	input  logic                              MHz10,
	input  logic                              nrst,
	input  logic                              ser_in,
	input  logic                              wave_btn,
	output logic [11:0]                       sample_out,
	output logic                              sample_valid,
	output logic [synth_pkg::NUM_VOICES-1:0]  voice_busy
);

	logic [7:0] byte_data;
	logic byte_valid;
	synth_pkg::midi_event_t midi_event;
	logic event_valid;
	logic sustain;
	logic frame_tick;
	synth_pkg::voice_cmd_t cmd [synth_pkg::NUM_VOICES];
	synth_pkg::voice_state_t states [synth_pkg::NUM_VOICES];

	uart_rx uart_rx0 (
		.MHz10(MHz10), .nrst(nrst), .ser_in(ser_in),
		.byte_data(byte_data), .byte_valid(byte_valid)
	);

	midi_parser midi_parser0 (
		.MHz10(MHz10), .nrst(nrst), .byte_data(byte_data), .byte_valid(byte_valid),
		.midi_event(midi_event), .event_valid(event_valid), .sustain(sustain)
	);

	voice_alloc voice_alloc0 (
		.MHz10(MHz10), .nrst(nrst), .midi_event(midi_event),
		.event_valid(event_valid), .states(states), .cmd(cmd)
	);

	for (genvar k = 0; k < synth_pkg::NUM_VOICES; k++) begin : g_voice
		voice_osc voice_osc0 (
			.MHz10(MHz10), .nrst(nrst), .cmd(cmd[k]), .sustain(sustain),
			.frame_tick(frame_tick), .state(states[k])
		);
		assign voice_busy[k] = states[k].busy; // front panel LEDs
	end

	voice_mixer voice_mixer0 (
		.MHz10(MHz10), .nrst(nrst), .wave_btn(wave_btn), .states(states),
		.frame_tick(frame_tick), .sample_out(sample_out), .sample_valid(sample_valid)
	);

endmodule

// ==== test/synth_ref.svh ====
logic [31:0] lfsr_state = 32'h7b88_ff8d;

// taps at 32 22 2 1, one step for each bit taken
function automatic logic [31:0] lfsr_take(input int n);
	logic [31:0] val;
	logic fb;
	val = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		val = {val[30:0], fb};
	end
	return val;
endfunction

task automatic abort_run(input string why);
	$display("%s", why);
	$display("ERRORS FOUND");
	$fatal(1);
endtask

task automatic compare_values(input string name, input int exp_v, input int act_v);
	if (exp_v != act_v)
		abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp_v, act_v));
endtask

// start bit, eight data bits lsb first, stop bit
task automatic send_byte(input logic [7:0] b);
	logic [9:0] frame;
	frame = {1'b1, b, 1'b0};
	for (int i = 0; i < 10; i++) begin
		ser_in = frame[i];
		repeat (synth_pkg::CLKS_PER_BIT) @(posedge MHz10);
		#10;
	end
endtask

////////////////////////////////////////////////////////////
// voice model
////////////////////////////////////////////////////////////

function automatic void ref_alloc(input logic [7:0] status, input logic [6:0] d1,
		input logic [6:0] d2);
	logic placed;
	logic is_off;
	placed = 1'b0;
	is_off = status[7:4] == 4'h8 || (status[7:4] == 4'h9 && d2 == 7'd0);
	if (status[7:4] == 4'hb && d1 == 7'd64) begin
		m_sustain = d2 >= 7'd64;
		if (!m_sustain) begin
			m_busy = m_busy & ~m_rel; // held notes end when the pedal lifts
			m_rel = '0;
		end
	end
	for (int k = 0; k < synth_pkg::NUM_VOICES; k++) begin
		if (status[7:4] == 4'h9 && d2 != 7'd0 && !placed && !m_busy[k]) begin
			placed = 1'b1; // lowest free voice takes the note
			m_busy[k] = 1'b1;
			m_note[k] = d1;
			m_vel[k] = d2;
		end else if (is_off && m_busy[k] && m_note[k] == d1) begin
			m_rel[k] = m_sustain;
			m_busy[k] = m_sustain;
		end
	end
endfunction

// each busy voice at its loudest phase for the given wave
function automatic int ref_peak(input synth_pkg::wave_e mode);
	int total;
	int best;
	int s;
	total = 0;
	for (int k = 0; k < synth_pkg::NUM_VOICES; k++) begin
		best = 0;
		for (int p = 0; p < 256; p++) begin
			case (mode)
				synth_pkg::WAVE_SQUARE: s = (p >= 128) ? 255 : 0;
				synth_pkg::WAVE_TRI:    s = (p >= 128) ? 255 - 2 * (p % 128) : 2 * p;
				default:                s = p;
			endcase
			if (m_busy[k] && (s * m_vel[k]) / 64 > best)
				best = (s * m_vel[k]) / 64; // upper 9 of 15 product bits
		end
		total += best;
	end
	return total;
endfunction

// ==== test/tb_poly_synth.sv ====
`timescale 1ns/1ps

module tb_poly_synth;

	logic MHz10 = 1'b0;
	logic nrst;
	logic ser_in;
	logic wave_btn;
	logic [11:0] sample_out;
	logic sample_valid;
	logic [synth_pkg::NUM_VOICES-1:0] voice_busy;

	logic [synth_pkg::NUM_VOICES-1:0] m_busy = '0;
	logic [synth_pkg::NUM_VOICES-1:0] m_rel = '0; // released but held by the pedal
	logic [6:0] m_note [synth_pkg::NUM_VOICES];
	logic [6:0] m_vel [synth_pkg::NUM_VOICES];
	logic m_sustain = 1'b0;
	synth_pkg::wave_e m_wave = synth_pkg::WAVE_SAW;
	int peak_bound = 0;
	int solo_amp = -1; // negative while the square level check is off
	bit seen_zero;
	bit seen_amp;
	int sample_cnt = 0;
	int clk_cnt;

	`include "synth_ref.svh"

	always #50 MHz10 = ~MHz10;

	poly_synth dut0 (
		.MHz10(MHz10), .nrst(nrst), .ser_in(ser_in), .wave_btn(wave_btn),
		.sample_out(sample_out), .sample_valid(sample_valid), .voice_busy(voice_busy)
	);

	task automatic wait_samples(input int n);
		int target;
		target = sample_cnt + n;
		clk_cnt = 0;
		while (sample_cnt < target && clk_cnt < (n + 1) * synth_pkg::FRAME_CLKS) begin
			@(posedge MHz10);
			#10;
			clk_cnt++;
		end
		if (sample_cnt < target)
			abort_run("timeout while waiting for sample_valid");
	endtask

	// the bound covers both voice sets until the change has reached the samples
	task automatic send_msg(input string name, input logic [7:0] status, d1, d2);
		int old_peak;
		old_peak = ref_peak(m_wave);
		ref_alloc(status, d1[6:0], d2[6:0]);
		peak_bound = (old_peak > ref_peak(m_wave)) ? old_peak : ref_peak(m_wave);
		send_byte(status);
		send_byte(d1);
		send_byte(d2);
		clk_cnt = 0;
		while (voice_busy !== m_busy && clk_cnt < synth_pkg::CLKS_PER_BIT) begin
			@(posedge MHz10);
			#10;
			clk_cnt++;
		end
		compare_values(name, m_busy, voice_busy);
		wait_samples(2);
		peak_bound = ref_peak(m_wave);
	endtask

	task automatic press_button();
		int old_peak;
		old_peak = ref_peak(m_wave);
		case (m_wave)
			synth_pkg::WAVE_SAW:    m_wave = synth_pkg::WAVE_SQUARE;
			synth_pkg::WAVE_SQUARE: m_wave = synth_pkg::WAVE_TRI;
			default:                m_wave = synth_pkg::WAVE_SAW;
		endcase
		peak_bound = (old_peak > ref_peak(m_wave)) ? old_peak : ref_peak(m_wave);
		wave_btn = 1'b1;
		repeat (4) @(posedge MHz10);
		#10;
		wave_btn = 1'b0;
		wait_samples(2);
		peak_bound = ref_peak(m_wave);
	endtask

	////////////////////////////////////////////////////////////
	// samples are read away from the rising edge
	////////////////////////////////////////////////////////////

	always @(negedge MHz10) begin : compare_samples
		if (nrst && sample_valid) begin
			sample_cnt++;
			if (int'(sample_out) > peak_bound)
				abort_run($sformatf(
					"[ERROR] sample within ref_peak: expected at most %0d, actual %0d",
					peak_bound, sample_out));
			if (solo_amp >= 0) begin
				if (sample_out != 0)
					compare_values("square level", solo_amp, sample_out);
				seen_zero |= sample_out == 0;
				seen_amp |= int'(sample_out) == solo_amp;
			end
		end
	end

	initial begin
		logic [7:0] note_v;
		logic [7:0] vel_v;
		ser_in = 1'b1;
		wave_btn = 1'b0;
		nrst = 1'b0;
		repeat (5) @(posedge MHz10);
		#10;
		nrst = 1'b1;
		compare_values("busy after reset", 0, voice_busy);
		wait_samples(4); // silent, so the bound is 0
		for (int i = 0; i < 9; i++) begin
			note_v = 8'(lfsr_take(7));
			vel_v = 8'(1 + lfsr_take(7) % 127);
			send_msg($sformatf("note on %0d", i), 8'h90, note_v, vel_v);
		end
		send_msg("note off", 8'h80, m_note[2], 8'd64);
		send_msg("note on velocity 0", 8'h90, m_note[5], 8'd0);
		send_msg("pedal down", 8'hb0, 8'd64, 8'd100);
		send_msg("note off under pedal", 8'h80, m_note[0], 8'd0);
		send_msg("note off under pedal", 8'h80, m_note[1], 8'd0);
		send_msg("pedal up", 8'hb0, 8'd64, 8'd0);
		for (int k = 0; k < synth_pkg::NUM_VOICES; k++) begin
			if (m_busy[k])
				send_msg("clear voices", 8'h80, m_note[k], 8'd0);
		end
		send_msg("solo note", 8'h90, 8'd60, 8'd100);
		press_button();
		seen_zero = 1'b0;
		seen_amp = 1'b0;
		solo_amp = ref_peak(m_wave);
		clk_cnt = 0;
		while (!(seen_zero && seen_amp) && clk_cnt < 4096 * synth_pkg::FRAME_CLKS) begin
			@(posedge MHz10);
			#10;
			clk_cnt++;
		end
		if (!(seen_zero && seen_amp))
			abort_run("square voice did not show both levels within 4096 frames");
		solo_amp = -1;
		for (int i = 0; i < 4; i++) begin
			note_v = 8'(lfsr_take(7));
			vel_v = 8'(1 + lfsr_take(7) % 127);
			send_msg($sformatf("chord note %0d", i), 8'h90, note_v, vel_v);
		end
		// square, then triangle, then saw
		for (int w = 0; w < 3; w++) begin
			wait_samples(64);
			press_button();
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== poly_synth.f ====
+incdir+test
source/synth_pkg.sv
source/uart_rx.sv
source/midi_parser.sv
source/voice_alloc.sv
source/voice_osc.sv
source/voice_mixer.sv
source/poly_synth.sv
test/tb_poly_synth.sv
